// ==== bit_corr_top.f ====
rtl/corr_pkg.sv
rtl/corr_regs.sv
rtl/lane_serializer.sv
rtl/bit_corr_core.sv
rtl/lane_packer.sv
rtl/bit_corr_top.sv
sim/bit_corr_chk.sv
sim/bit_corr_tb.sv

// ==== Bender.yml ====
package:
  name: bit_corr

sources:
  # design, in compile order
  - files:
      - rtl/corr_pkg.sv
      - rtl/corr_regs.sv
      - rtl/lane_serializer.sv
      - rtl/bit_corr_core.sv
      - rtl/lane_packer.sv
      - rtl/bit_corr_top.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/bit_corr_chk.sv
      - sim/bit_corr_tb.sv

// ==== sim/bit_corr_tb.sv ====
// testbench: clock, lfsr stimulus, reference model, compare tasks,
// output monitor and watchdog for the lane correlator
`timescale 1ns/100ps
`default_nettype none

module bit_corr_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int TOTAL_BEATS = 112;
  localparam int REG_OPS     = 30;
  // beats at 4 cycles each, doubled for back-pressure, then a 2x margin
  localparam int WATCHDOG_NS = 2 * (TOTAL_BEATS * 8 + REG_OPS * 8 + 20) * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  corr_pkg::axil_req_t  axil_req;
  corr_pkg::axil_rsp_t  axil_rsp;
  logic                 s_valid;
  logic                 s_ready;
  corr_pkg::in_beat_t   s_data;
  logic                 m_valid;
  logic                 m_ready;
  corr_pkg::out_beat_t  m_data;

  logic [31:0]          lfsr_state;
  logic [31:0]          ready_state;
  logic                 bp_en;
  corr_pkg::taps_t      cur_taps;
  corr_pkg::acc_t       cur_thresh;
  corr_pkg::sample_t    hist [corr_pkg::NUM_LANES][corr_pkg::CORR_LEN];
  corr_pkg::out_beat_t  exp_q [$];
  corr_pkg::hit_count_t exp_hits;
  int                   err_count;
  int                   n_checks;

  bit_corr_top u_bit_corr_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_data   (s_data),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_data   (m_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  //////////////////////////////
  // random source
  //////////////////////////////

  // 32-bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // y[n] is the sum of c[k] * x[n-k] with c[k] = +1 for a set tap bit and -1 otherwise
  function automatic corr_pkg::out_beat_t ref_beat(input corr_pkg::in_beat_t b,
                                                   input corr_pkg::taps_t t,
                                                   input corr_pkg::acc_t thr);
    corr_pkg::out_beat_t o;
    int acc;
    int mag;
    for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
      for (int k = corr_pkg::CORR_LEN - 1; k > 0; k--) begin
        hist[l][k] = hist[l][k-1];
      end
      hist[l][0] = b.samples[l];
      acc = 0;
      for (int k = 0; k < corr_pkg::CORR_LEN; k++) begin
        acc = t[k] ? acc + int'(hist[l][k]) : acc - int'(hist[l][k]);
      end
      mag = (acc < 0) ? -acc : acc;
      o.sums[l]     = corr_pkg::acc_t'(acc);
      o.hit_mask[l] = (mag >= int'(thr));
    end
    if (o.hit_mask != '0) begin
      exp_hits++;
    end
    return o;
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_beat(input corr_pkg::out_beat_t got, input corr_pkg::out_beat_t exp);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t: out beat sums %h mask %b, expected sums %h mask %b",
               $time, got.sums, got.hit_mask, exp.sums, exp.hit_mask);
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [1:0] got_resp,
                           input logic [31:0] exp, input logic [1:0] exp_resp,
                           input string what);
    n_checks++;
    if (got !== exp || got_resp !== exp_resp) begin
      err_count++;
      $display("FAIL %0t: %s read %h resp %b, expected %h resp %b",
               $time, what, got, got_resp, exp, exp_resp);
    end
  endtask

  task automatic check_count(input corr_pkg::hit_count_t got,
                             input corr_pkg::hit_count_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t: %s hit count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // bus and stream drivers
  //////////////////////////////

  // all drivers start and end 1 ns after a rising edge
  task automatic write_reg(input logic [corr_pkg::ADDR_W-1:0] addr,
                           input logic [31:0] data, output logic [1:0] resp);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    @(negedge clk);
    while (!axil_rsp.awready || !axil_rsp.wready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) begin
      @(negedge clk);
    end
    resp = axil_rsp.bresp;
    // response waits one cycle before bready
    @(posedge clk);
    #1;
    axil_req.bready = 1'b1;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [corr_pkg::ADDR_W-1:0] addr,
                          output logic [31:0] data, output logic [1:0] resp);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    @(negedge clk);
    while (!axil_rsp.arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) begin
      @(negedge clk);
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    // read data waits one cycle before rready
    @(posedge clk);
    #1;
    axil_req.rready = 1'b1;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic send_beat(input corr_pkg::in_beat_t b);
    s_valid = 1'b1;
    s_data  = b;
    @(negedge clk);
    while (!s_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    s_valid = 1'b0;
    exp_q.push_back(ref_beat(b, cur_taps, cur_thresh));
  endtask

  task automatic send_random_beats(input int n);
    corr_pkg::in_beat_t b;
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
        rand_bits(corr_pkg::SAMPLE_W, v);
        b.samples[l] = corr_pkg::sample_t'(v[corr_pkg::SAMPLE_W-1:0]);
      end
      send_beat(b);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, err_count - errs_before);
  endtask

  //////////////////////////////
  // output side
  //////////////////////////////

  // random low periods on m_ready while back-pressure is on
  initial begin
    ready_state = 32'hae6a4da1;
    forever begin
      @(posedge clk);
      #1;
      if (bp_en) begin
        ready_state = lfsr_next(ready_state);
        m_ready = ready_state[0];
      end else begin
        m_ready = 1'b1;
      end
    end
  end

  // a transfer seen at the falling edge completes on the next rising edge
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("ERROR %0t: output beat arrived with no beat expected", $time);
        end else begin
          check_beat(m_data, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [1:0]  resp;
    logic [31:0] v;
    int          errs;
    int          total;
    rst_n      = 1'b0;
    axil_req   = '0;
    s_valid    = 1'b0;
    s_data     = '0;
    m_ready    = 1'b1;
    bp_en      = 1'b0;
    lfsr_state = 32'hae6a4da1;
    cur_taps   = '1;
    cur_thresh = {1'b0, {(corr_pkg::ACC_W-1){1'b1}}};
    exp_hits   = '0;
    err_count  = 0;
    n_checks   = 0;
    for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
      for (int k = 0; k < corr_pkg::CORR_LEN; k++) begin
        hist[l][k] = '0;
      end
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // 1: reset values and unknown address
    errs = err_count;
    read_reg(4'h0, rd, resp);
    check_reg(rd, resp, 32'h0000_00ff, 2'b00, "TAPS");
    read_reg(4'h4, rd, resp);
    check_reg(rd, resp, 32'h0000_07ff, 2'b00, "THRESH");
    read_reg(4'h8, rd, resp);
    check_reg(rd, resp, 32'h0, 2'b00, "HITS");
    read_reg(4'hc, rd, resp);
    check_reg(rd, resp, 32'h0, 2'b10, "unknown address");
    write_reg(4'hc, 32'h0000_0012, resp);
    check_reg(32'h0, resp, 32'h0, 2'b10, "unknown address write");
    read_reg(4'h0, rd, resp);
    check_reg(rd, resp, 32'h0000_00ff, 2'b00, "TAPS after bad write");
    read_reg(4'h4, rd, resp);
    check_reg(rd, resp, 32'h0000_07ff, 2'b00, "THRESH after bad write");
    report_test("1 reset values", errs);

    // 2: default taps from zero history
    errs = err_count;
    send_random_beats(24);
    wait_drain();
    report_test("2 default taps", errs);

    // 3: tap changes between beats, history carries over
    errs = err_count;
    for (int r = 0; r < 2; r++) begin
      rand_bits(corr_pkg::CORR_LEN, v);
      write_reg(4'h0, v, resp);
      check_reg(32'h0, resp, 32'h0, 2'b00, "TAPS write");
      cur_taps = corr_pkg::taps_t'(v);
      read_reg(4'h0, rd, resp);
      check_reg(rd, resp, {24'h0, cur_taps}, 2'b00, "TAPS after write");
      send_random_beats(12);
    end
    wait_drain();
    report_test("3 tap changes", errs);

    // 4: random output back-pressure
    errs = err_count;
    bp_en = 1'b1;
    send_random_beats(40);
    wait_drain();
    bp_en = 1'b0;
    report_test("4 back-pressure", errs);

    // 5: low threshold, hit mask and hit counter
    errs = err_count;
    write_reg(4'h8, 32'h0, resp);
    exp_hits = '0;
    rand_bits(6, v);
    cur_thresh = corr_pkg::acc_t'(16 + v[5:0]);
    write_reg(4'h4, 32'(cur_thresh), resp);
    check_reg(32'h0, resp, 32'h0, 2'b00, "THRESH write");
    bp_en = 1'b1;
    send_random_beats(24);
    wait_drain();
    bp_en = 1'b0;
    read_reg(4'h8, rd, resp);
    check_count(rd[15:0], exp_hits, "after hit beats");
    write_reg(4'h8, 32'h0, resp);
    check_reg(32'h0, resp, 32'h0, 2'b00, "HITS clear write");
    read_reg(4'h8, rd, resp);
    check_count(rd[15:0], '0, "after clear");
    report_test("5 threshold and hits", errs);

    total = err_count + u_bit_corr_top.u_bit_corr_chk.assert_fails;
    $display("checks %0d, errors %0d, assertion failures %0d",
             n_checks, err_count, u_bit_corr_top.u_bit_corr_chk.assert_fails);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/bit_corr_chk.sv ====
// stream and axi4-lite handshake assertions, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module bit_corr_chk (
  input logic                clk,
  input logic                rst_n,
  input logic                m_valid,
  input logic                m_ready,
  input corr_pkg::out_beat_t m_data,
  input corr_pkg::axil_req_t axil_req,
  input corr_pkg::axil_rsp_t axil_rsp
);

  int unsigned assert_fails = 0;

  // output beat holds until taken
  a_m_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else begin
      assert_fails++;
      $error("m_data or m_valid changed before the transfer");
    end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      assert_fails++;
      $error("bvalid dropped before bready");
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
      assert_fails++;
      $error("rvalid dropped before rready");
    end

  // first cycle out of reset
  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !m_valid && !axil_rsp.bvalid && !axil_rsp.rvalid)
    else begin
      assert_fails++;
      $error("valid outputs not cleared by reset");
    end

endmodule

bind bit_corr_top bit_corr_chk u_bit_corr_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_data   (m_data),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

`default_nettype wire

// ==== rtl/bit_corr_top.sv ====
// top level: register block and the serializer, core
// and packer stream pipeline
`timescale 1ns/100ps
`default_nettype none

module bit_corr_top (
  input  logic                clk,
  input  logic                rst_n,
  input  corr_pkg::axil_req_t axil_req,
  output corr_pkg::axil_rsp_t axil_rsp,
  input  logic                s_valid,
  output logic                s_ready,
  input  corr_pkg::in_beat_t  s_data,
  output logic                m_valid,
  input  logic                m_ready,
  output corr_pkg::out_beat_t m_data
);

  corr_pkg::taps_t      taps;
  corr_pkg::acc_t       thresh;
  logic                 hit_beat;
  logic                 advance;
  logic                 item_valid;
  corr_pkg::lane_item_t item;
  logic                 sum_valid;
  corr_pkg::lane_sum_t  sum;

  corr_regs u_corr_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .hit_beat (hit_beat),
    .taps     (taps),
    .thresh   (thresh)
  );

  lane_serializer u_lane_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .taps       (taps),
    .advance    (advance),
    .item_valid (item_valid),
    .item       (item)
  );

  bit_corr_core u_bit_corr_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .item_valid (item_valid),
    .item       (item),
    .advance    (advance),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  lane_packer u_lane_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .sum_valid (sum_valid),
    .sum       (sum),
    .thresh    (thresh),
    .advance   (advance),
    .hit_beat  (hit_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data)
  );

endmodule

`default_nettype wire

// ==== rtl/lane_packer.sv ====
// collects lane sums into an output beat with hit mask
// and owns the output register and back-pressure
`timescale 1ns/100ps
`default_nettype none

module lane_packer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sum_valid,
  input  corr_pkg::lane_sum_t sum,
  input  corr_pkg::acc_t      thresh,
  output logic                advance,
  output logic                hit_beat,
  output logic                m_valid,
  input  logic                m_ready,
  output corr_pkg::out_beat_t m_data
);

  logic                                     take;
  logic                                     load;
  logic                                     complete;
  corr_pkg::acc_t [corr_pkg::NUM_LANES-1:0] sums_q;
  corr_pkg::hit_mask_t                      mask_q;

  // |s| >= t, one extra bit keeps the negation exact
  function automatic logic mag_hit(corr_pkg::acc_t s, corr_pkg::acc_t t);
    logic signed [corr_pkg::ACC_W:0] ext;
    ext = $signed({s[corr_pkg::ACC_W-1], s});
    if (ext < 0) begin
      ext = -ext;
    end
    return ext >= $signed({t[corr_pkg::ACC_W-1], t});
  endfunction

  // stall only with a finished beat and a full, waiting output
  assign advance = !(complete && m_valid && !m_ready);
  assign load    = complete && (!m_valid || m_ready);
  assign take    = sum_valid && advance;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      complete <= 1'b0;
    end else if (take) begin
      complete <= sum.last;
    end else if (load) begin
      complete <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sums_q[sum.lane] <= sum.acc;
      mask_q[sum.lane] <= mag_hit(sum.acc, thresh);
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid  <= 1'b0;
      hit_beat <= 1'b0;
    end else begin
      hit_beat <= load && (|mask_q);
      if (load) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_data.sums     <= sums_q;
      m_data.hit_mask <= mask_q;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bit_corr_core.sv ====
// per-lane sample history and a registered adder tree
// over +1/-1 taps, one lane per cycle
`timescale 1ns/100ps
`default_nettype none

module bit_corr_core (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 item_valid,
  input  corr_pkg::lane_item_t item,
  input  logic                 advance,
  output logic                 sum_valid,
  output corr_pkg::lane_sum_t  sum
);

  localparam int HIST_LEN = corr_pkg::CORR_LEN - 1;
  localparam int TREE_N   = 2 * corr_pkg::CORR_LEN - 1;

  logic take;

  // previous samples per lane, index 0 is x[n-1]
  corr_pkg::sample_t [HIST_LEN-1:0] hist [corr_pkg::NUM_LANES];

  corr_pkg::sample_t window [corr_pkg::CORR_LEN];
  corr_pkg::acc_t    terms  [corr_pkg::CORR_LEN];
  corr_pkg::acc_t    tree   [TREE_N];

  assign take = item_valid && advance;

  //////////////////////////////
  // sample history
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int l = 0; l < corr_pkg::NUM_LANES; l++) begin
        hist[l] <= '0;
      end
    end else if (take) begin
      hist[item.lane] <= {hist[item.lane][HIST_LEN-2:0], item.sample};
    end
  end

  // x[n] from the item, x[n-k] from the lane's history
  always_comb begin
    window[0] = item.sample;
    for (int k = 1; k < corr_pkg::CORR_LEN; k++) begin
      window[k] = hist[item.lane][k-1];
    end
  end

  //////////////////////////////
  // signed terms and tree
  //////////////////////////////

  // tap bit set gives +1, clear gives -1
  always_comb begin
    for (int k = 0; k < corr_pkg::CORR_LEN; k++) begin
      terms[k] = item.taps[k] ? corr_pkg::acc_t'(window[k])
                              : -corr_pkg::acc_t'(window[k]);
    end
  end

  // heap layout, leaves at the top half and the root in slot 0
  always_comb begin
    for (int i = 0; i < corr_pkg::CORR_LEN; i++) begin
      tree[corr_pkg::CORR_LEN - 1 + i] = terms[i];
    end
    for (int i = corr_pkg::CORR_LEN - 2; i >= 0; i--) begin
      tree[i] = tree[2*i + 1] + tree[2*i + 2];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else if (advance) begin
      sum_valid <= item_valid;
    end
  end

  // output holds while advance is low
  always_ff @(posedge clk) begin
    if (take) begin
      sum.acc  <= tree[0];
      sum.lane <= item.lane;
      sum.last <= item.last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lane_serializer.sv ====
// input stage: holds one beat and issues its lanes
// one per advancing cycle, tagged with lane and taps
`timescale 1ns/100ps
`default_nettype none

module lane_serializer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  corr_pkg::in_beat_t   s_data,
  input  corr_pkg::taps_t      taps,
  input  logic                 advance,
  output logic                 item_valid,
  output corr_pkg::lane_item_t item
);

  logic               busy;
  logic               last_lane;
  corr_pkg::lane_t    lane_q;
  corr_pkg::in_beat_t beat_q;
  corr_pkg::taps_t    taps_q;

  assign last_lane = (lane_q == corr_pkg::lane_t'(corr_pkg::NUM_LANES - 1));

  // accept when idle or while the last lane leaves
  assign s_ready = !busy || (last_lane && advance);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      lane_q <= '0;
    end else if (s_valid && s_ready) begin
      busy   <= 1'b1;
      lane_q <= '0;
    end else if (busy && advance) begin
      if (last_lane) begin
        busy <= 1'b0;
      end
      lane_q <= lane_q + 1'b1;
    end
  end

  // taps are sampled with the beat
  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      beat_q <= s_data;
      taps_q <= taps;
    end
  end

  assign item_valid  = busy;
  assign item.taps   = taps_q;
  assign item.last   = last_lane;
  assign item.lane   = lane_q;
  assign item.sample = beat_q.samples[lane_q];

endmodule

`default_nettype wire

// ==== rtl/corr_regs.sv ====
// axi4-lite register block: tap pattern, hit threshold
// and a saturating counter of output beats with hits
`timescale 1ns/100ps
`default_nettype none

module corr_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  corr_pkg::axil_req_t axil_req,
  output corr_pkg::axil_rsp_t axil_rsp,
  input  logic                hit_beat,
  output corr_pkg::taps_t     taps,
  output corr_pkg::acc_t      thresh
);

  logic                        wr_fire;
  logic                        wr_hit;
  logic                        rd_fire;
  logic                        bvalid;
  logic [1:0]                  bresp;
  logic                        rvalid;
  logic [corr_pkg::DATA_W-1:0] rdata;
  logic [1:0]                  rresp;
  logic [corr_pkg::DATA_W-1:0] rd_word;
  logic                        rd_known;
  corr_pkg::hit_count_t        hit_count;

  //////////////////////////////
  // write channel
  //////////////////////////////

  // aw and w are taken together, one write at a time
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;

  assign wr_hit = (axil_req.awaddr == corr_pkg::REG_TAPS) ||
                  (axil_req.awaddr == corr_pkg::REG_THRESH) ||
                  (axil_req.awaddr == corr_pkg::REG_HITS);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      taps   <= corr_pkg::TAPS_RESET;
      thresh <= corr_pkg::THRESH_RESET;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
        if (axil_req.awaddr == corr_pkg::REG_TAPS) begin
          taps <= axil_req.wdata[corr_pkg::CORR_LEN-1:0];
        end
        if (axil_req.awaddr == corr_pkg::REG_THRESH) begin
          thresh <= axil_req.wdata[corr_pkg::ACC_W-1:0];
        end
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_hit ? corr_pkg::RESP_OKAY : corr_pkg::RESP_SLVERR;
    end
  end

  // clearing write takes priority over a hit in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_count <= '0;
    end else if (wr_fire && axil_req.awaddr == corr_pkg::REG_HITS) begin
      hit_count <= '0;
    end else if (hit_beat && hit_count != '1) begin
      hit_count <= hit_count + 1'b1;
    end
  end

  //////////////////////////////
  // read channel
  //////////////////////////////

  assign rd_fire = axil_req.arvalid && !rvalid;

  always_comb begin
    rd_word  = '0;
    rd_known = 1'b1;
    case (axil_req.araddr)
      corr_pkg::REG_TAPS:   rd_word = corr_pkg::DATA_W'(taps);
      // threshold reads back sign extended
      corr_pkg::REG_THRESH: rd_word = corr_pkg::DATA_W'(thresh);
      corr_pkg::REG_HITS:   rd_word = corr_pkg::DATA_W'(hit_count);
      default:              rd_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_known ? corr_pkg::RESP_OKAY : corr_pkg::RESP_SLVERR;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = !rvalid;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

endmodule

`default_nettype wire

// ==== rtl/corr_pkg.sv ====
// widths, typedefs, register map and stream structs
// shared by the correlator pipeline and its register block
`default_nettype none

package corr_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int NUM_LANES = 4;
  localparam int SAMPLE_W  = 6;
  localparam int CORR_LEN  = 8;
  // 8 taps times a magnitude of 32 fits easily
  localparam int ACC_W     = 12;
  localparam int LANE_W    = $clog2(NUM_LANES);
  localparam int ADDR_W    = 4;
  localparam int DATA_W    = 32;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic [CORR_LEN-1:0]        taps_t;
  typedef logic [LANE_W-1:0]          lane_t;
  typedef logic [NUM_LANES-1:0]       hit_mask_t;
  typedef logic [15:0]                hit_count_t;

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [ADDR_W-1:0] REG_TAPS   = 4'h0;
  localparam logic [ADDR_W-1:0] REG_THRESH = 4'h4;
  localparam logic [ADDR_W-1:0] REG_HITS   = 4'h8;

  localparam taps_t TAPS_RESET   = '1;
  localparam acc_t  THRESH_RESET = {1'b0, {(ACC_W-1){1'b1}}};

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  //////////////////////////////
  // stream payloads
  //////////////////////////////

  // lane 0 sits in the lowest bits
  typedef struct packed {
    sample_t [NUM_LANES-1:0] samples;
  } in_beat_t;

  typedef struct packed {
    taps_t   taps;
    logic    last;
    lane_t   lane;
    sample_t sample;
  } lane_item_t;

  typedef struct packed {
    logic  last;
    lane_t lane;
    acc_t  acc;
  } lane_sum_t;

  typedef struct packed {
    hit_mask_t            hit_mask;
    acc_t [NUM_LANES-1:0] sums;
  } out_beat_t;

  // axi4-lite channel bundles
  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire
